/* design/isaPkg.sv */
//**************************************************
// MIPS instruction-set definitions for the core
// Word and register number types, the instruction
// word views, opcodes and R-type function codes
//**************************************************
package isaPkg;

	localparam int dataWidth = 32; // Machine word
	localparam int regAddrWidth = 5; // 32 registers

	typedef logic [dataWidth-1:0] word_t;
	typedef logic [regAddrWidth-1:0] regAddr_t;

	// R-format fields
	typedef struct packed {
		logic [5:0] opcode;
		regAddr_t rs;
		regAddr_t rt;
		regAddr_t rd;
		logic [4:0] shamt; // Shift amount for sll/srl
		logic [5:0] funct;
	} rFields_t;

	// I-format fields, also holds the 26-bit jump index in its low bits
	typedef struct packed {
		logic [5:0] opcode;
		regAddr_t rs;
		regAddr_t rt;
		logic [15:0] imm;
	} iFields_t;

	typedef union packed {
		rFields_t r;
		iFields_t i;
	} instr_t;

	// Opcodes
	localparam logic [5:0] opR = 6'h00; // Decoded further by funct
	localparam logic [5:0] opJ = 6'h02;
	localparam logic [5:0] opJal = 6'h03;
	localparam logic [5:0] opBeq = 6'h04;
	localparam logic [5:0] opBne = 6'h05;
	localparam logic [5:0] opAddi = 6'h08;
	localparam logic [5:0] opSlti = 6'h0a;
	localparam logic [5:0] opAndi = 6'h0c;
	localparam logic [5:0] opOri = 6'h0d;
	localparam logic [5:0] opLui = 6'h0f;
	localparam logic [5:0] opLw = 6'h23;
	localparam logic [5:0] opSw = 6'h2b;

	// Function codes
	localparam logic [5:0] fnSll = 6'h00;
	localparam logic [5:0] fnSrl = 6'h02;
	localparam logic [5:0] fnJr = 6'h08;
	localparam logic [5:0] fnMovz = 6'h0a;
	localparam logic [5:0] fnMovn = 6'h0b;
	localparam logic [5:0] fnAdd = 6'h20;
	localparam logic [5:0] fnSub = 6'h22;
	localparam logic [5:0] fnAnd = 6'h24;
	localparam logic [5:0] fnOr = 6'h25;
	localparam logic [5:0] fnXor = 6'h26;
	localparam logic [5:0] fnNor = 6'h27;
	localparam logic [5:0] fnSlt = 6'h2a;

	localparam regAddr_t regRa = 5'd31; // Link register for jal

endpackage

/* design/pipePkg.sv */
//**************************************************
// Pipeline control encodings shared by the decoder,
// ALU, forwarding logic and the datapath top
//**************************************************
package pipePkg;

	// Operation class from the main decoder
	typedef enum logic [1:0] {
		aluOpAdd, // Address calc for lw/sw
		aluOpSub, // Compare class, branches
		aluOpFunct, // R-type, look at funct
		aluOpImm // Immediate ops, look at opcode
	} aluOp_t;

	// Operation the ALU actually performs
	typedef enum logic [3:0] {
		ctlAdd,
		ctlSub,
		ctlAnd,
		ctlOr,
		ctlXor,
		ctlNor,
		ctlSlt, // Signed compare
		ctlSll,
		ctlSrl,
		ctlLui // Immediate to upper half
	} aluCtl_t;

	// B operand source
	typedef enum logic [1:0] {
		srcReg,
		srcSignImm,
		srcZeroImm
	} aluSrc_t;

	// Destination register field
	typedef enum logic [1:0] {
		dstRt,
		dstRd,
		dstRa // Register 31 on jal
	} regDst_t;

	// Operand source in EX
	typedef enum logic [1:0] {
		fwdNone, // Value read in ID
		fwdFromWb,
		fwdFromMem
	} fwdSel_t;

	localparam logic [31:0] nopInstr = 32'h0000_0000; // sll $0,$0,0

endpackage

/* design/regFile.sv */
//**************************************************
// Register file, 32 x 32 bits, two read ports
// Read is combinational, write lands at the edge
// WB write is visible to a same-cycle read
//**************************************************
module regFile (
	input logic iCLK,
	input logic iRST,
	input isaPkg::regAddr_t readAddrA,
	input isaPkg::regAddr_t readAddrB,
	input isaPkg::regAddr_t writeAddr,
	input isaPkg::word_t writeData,
	input logic writeEn,
	output isaPkg::word_t readDataA,
	output isaPkg::word_t readDataB
);

	isaPkg::word_t regs [2**isaPkg::regAddrWidth];

	always_ff @(posedge iCLK) begin
		if (iRST) begin
			for (int i = 0; i < 2**isaPkg::regAddrWidth; i++)
				regs[i] <= '0;
		end else if (writeEn && writeAddr != '0) begin
			regs[writeAddr] <= writeData; // $zero never stored
		end
	end

	// $zero reads zero, then bypass, then array
	assign readDataA = (readAddrA == '0) ? '0 :
		(writeEn && writeAddr == readAddrA) ? writeData : regs[readAddrA];
	assign readDataB = (readAddrB == '0) ? '0 :
		(writeEn && writeAddr == readAddrB) ? writeData : regs[readAddrB];

endmodule

/* design/controlUnit.sv */
//**************************************************
// Main decoder, instruction word in ID to the
// control bits carried down the pipeline
//**************************************************
module controlUnit (
	input isaPkg::instr_t instr,
	output pipePkg::regDst_t regDst,
	output pipePkg::aluSrc_t aluSrc,
	output pipePkg::aluOp_t aluOp,
	output logic regWrite,
	output logic memRead,
	output logic memWrite,
	output logic branchEq,
	output logic branchNe,
	output logic jump,
	output logic jumpReg,
	output logic link,
	output logic movN,
	output logic movZ
);

	always_comb begin
		// Defaults act as a nop
		regDst = pipePkg::dstRt;
		aluSrc = pipePkg::srcReg;
		aluOp = pipePkg::aluOpAdd;
		{regWrite, memRead, memWrite} = 3'b000;
		{branchEq, branchNe, jump, jumpReg, link} = 5'b00000;
		{movN, movZ} = 2'b00;
		case (instr.r.opcode)
			isaPkg::opR: begin
				regDst = pipePkg::dstRd;
				aluOp = pipePkg::aluOpFunct;
				case (instr.r.funct)
					isaPkg::fnJr: jumpReg = 1'b1; // No write
					isaPkg::fnMovn: movN = 1'b1; // Write decided later from rt
					isaPkg::fnMovz: movZ = 1'b1;
					default: regWrite = 1'b1;
				endcase
			end
			isaPkg::opJ: jump = 1'b1;
			isaPkg::opJal: begin
				jump = 1'b1;
				link = 1'b1; // Stores PC+4
				regDst = pipePkg::dstRa;
				regWrite = 1'b1;
			end
			isaPkg::opBeq: begin
				branchEq = 1'b1; // Resolved in ID
				aluOp = pipePkg::aluOpSub;
			end
			isaPkg::opBne: begin
				branchNe = 1'b1;
				aluOp = pipePkg::aluOpSub;
			end
			isaPkg::opAddi, isaPkg::opSlti: begin
				aluSrc = pipePkg::srcSignImm;
				aluOp = pipePkg::aluOpImm;
				regWrite = 1'b1;
			end
			isaPkg::opAndi, isaPkg::opOri, isaPkg::opLui: begin
				aluSrc = pipePkg::srcZeroImm; // Logic ops zero-extend
				aluOp = pipePkg::aluOpImm;
				regWrite = 1'b1;
			end
			isaPkg::opLw: begin
				aluSrc = pipePkg::srcSignImm;
				memRead = 1'b1;
				regWrite = 1'b1;
			end
			isaPkg::opSw: begin
				aluSrc = pipePkg::srcSignImm;
				memWrite = 1'b1;
			end
			default: ; // Unknown opcode runs as nop
		endcase
	end

endmodule

/* design/aluUnit.sv */
//**************************************************
// EX stage ALU with its operation decode
// Zero flag reports b == 0 for movn/movz
//**************************************************
module aluUnit (
	input pipePkg::aluOp_t aluOp,
	input isaPkg::instr_t instr,
	input isaPkg::word_t a,
	input isaPkg::word_t b,
	output isaPkg::word_t result,
	output logic zero
);

	pipePkg::aluCtl_t ctl;

	// Class plus funct/opcode to ALU operation
	always_comb begin
		ctl = pipePkg::ctlAdd;
		case (aluOp)
			pipePkg::aluOpSub: ctl = pipePkg::ctlSub;
			pipePkg::aluOpFunct: begin
				case (instr.r.funct)
					isaPkg::fnAdd: ctl = pipePkg::ctlAdd;
					isaPkg::fnSub: ctl = pipePkg::ctlSub;
					isaPkg::fnAnd: ctl = pipePkg::ctlAnd;
					isaPkg::fnOr: ctl = pipePkg::ctlOr;
					isaPkg::fnXor: ctl = pipePkg::ctlXor;
					isaPkg::fnNor: ctl = pipePkg::ctlNor;
					isaPkg::fnSlt: ctl = pipePkg::ctlSlt;
					isaPkg::fnSll: ctl = pipePkg::ctlSll;
					isaPkg::fnSrl: ctl = pipePkg::ctlSrl;
					default: ctl = pipePkg::ctlAdd; // jr, movn, movz
				endcase
			end
			pipePkg::aluOpImm: begin
				case (instr.i.opcode)
					isaPkg::opSlti: ctl = pipePkg::ctlSlt;
					isaPkg::opAndi: ctl = pipePkg::ctlAnd;
					isaPkg::opOri: ctl = pipePkg::ctlOr;
					isaPkg::opLui: ctl = pipePkg::ctlLui;
					default: ctl = pipePkg::ctlAdd; // addi
				endcase
			end
			default: ctl = pipePkg::ctlAdd;
		endcase
	end

	always_comb begin
		case (ctl)
			pipePkg::ctlSub: result = a - b;
			pipePkg::ctlAnd: result = a & b;
			pipePkg::ctlOr: result = a | b;
			pipePkg::ctlXor: result = a ^ b;
			pipePkg::ctlNor: result = ~(a | b);
			pipePkg::ctlSlt: result = {31'b0, $signed(a) < $signed(b)};
			pipePkg::ctlSll: result = b << instr.r.shamt; // Shifts act on rt
			pipePkg::ctlSrl: result = b >> instr.r.shamt;
			pipePkg::ctlLui: result = {b[15:0], 16'h0000};
			default: result = a + b;
		endcase
	end

	assign zero = (b == '0);

endmodule

/* design/forwardUnit.sv */
//**************************************************
// Forwarding selects for the EX operands and for
// the branch comparator in ID
//**************************************************
module forwardUnit (
	input isaPkg::regAddr_t exRs,
	input isaPkg::regAddr_t exRt,
	input isaPkg::regAddr_t idRs,
	input isaPkg::regAddr_t idRt,
	input isaPkg::regAddr_t memDst,
	input isaPkg::regAddr_t wbDst,
	input logic memRegWrite, // Already resolved for movn/movz
	input logic wbWriteEn,
	output pipePkg::fwdSel_t fwdA,
	output pipePkg::fwdSel_t fwdB,
	output logic fwdBranchA,
	output logic fwdBranchB
);

	logic memValid;
	logic wbValid;

	// Writers that really produce a register value
	assign memValid = memRegWrite && memDst != '0;
	assign wbValid = wbWriteEn && wbDst != '0;

	// MEM is the younger result, it wins over WB
	always_comb begin
		fwdA = pipePkg::fwdNone;
		if (memValid && memDst == exRs)
			fwdA = pipePkg::fwdFromMem;
		else if (wbValid && wbDst == exRs)
			fwdA = pipePkg::fwdFromWb;
	end

	always_comb begin
		fwdB = pipePkg::fwdNone;
		if (memValid && memDst == exRt)
			fwdB = pipePkg::fwdFromMem;
		else if (wbValid && wbDst == exRt)
			fwdB = pipePkg::fwdFromWb;
	end

	// ID comparator, WB case is covered by the register file bypass
	assign fwdBranchA = memValid && memDst == idRs;
	assign fwdBranchB = memValid && memDst == idRt;

endmodule

/* design/hazardUnit.sv */
//**************************************************
// Stall detection for load-use into EX and for
// branch/jr operands not yet available in ID
//**************************************************
module hazardUnit (
	input isaPkg::regAddr_t idRs,
	input isaPkg::regAddr_t idRt,
	input isaPkg::regAddr_t exDst,
	input isaPkg::regAddr_t memDst,
	input logic exMemRead,
	input logic exRegWrite,
	input logic memMemRead,
	input logic usesBranchOperands, // beq, bne, jr
	output logic stall
);

	logic exHit;
	logic memHit;
	logic loadUse;
	logic branchWait;

	// ID source matches, $zero never counts
	assign exHit = exDst != '0 && (exDst == idRs || exDst == idRt);
	assign memHit = memDst != '0 && (memDst == idRs || memDst == idRt);

	assign loadUse = exMemRead && exHit; // One bubble
	// Comparator only forwards from MEM ALU results
	assign branchWait = usesBranchOperands &&
		((exRegWrite && exHit) || (memMemRead && memHit));

	assign stall = loadUse || branchWait;

endmodule

/* design/mipsPipeline.sv */
//**************************************************
// Five-stage MIPS core, IF ID EX MEM WB
// Instruction and data memories sit outside and
// answer combinationally; branches resolve in ID
//**************************************************
module mipsPipeline (
	input logic iCLK,
	input logic iRST,
	input isaPkg::word_t initialPc,
	output isaPkg::word_t instrAddr,
	input isaPkg::word_t instrData,
	output isaPkg::word_t dataAddr,
	output isaPkg::word_t dataWriteData,
	output logic dataRead,
	output logic dataWrite,
	input isaPkg::word_t dataReadData
);

	// IF and IF/ID
	isaPkg::word_t pc, ifPc4, nextPc;
	isaPkg::word_t ifIdPc4;
	isaPkg::instr_t ifIdInstr;
	// ID
	pipePkg::regDst_t idRegDst;
	pipePkg::aluSrc_t idAluSrc;
	pipePkg::aluOp_t idAluOp;
	logic idRegWrite, idMemRead, idMemWrite, idBranchEq, idBranchNe;
	logic idJump, idJumpReg, idLink, idMovN, idMovZ;
	isaPkg::word_t idRegA, idRegB, idCmpA, idCmpB, idBranchTarget, idJumpTarget;
	logic idTaken, redirect, stall, fwdBranchA, fwdBranchB;
	// ID/EX
	isaPkg::instr_t exInstr;
	isaPkg::word_t exPc4, exRegA, exRegB;
	pipePkg::regDst_t exRegDst;
	pipePkg::aluSrc_t exAluSrc;
	pipePkg::aluOp_t exAluOp;
	logic exRegWrite, exMemRead, exMemWrite, exLink, exMovN, exMovZ;
	// EX
	pipePkg::fwdSel_t fwdA, fwdB;
	isaPkg::word_t exOpA, exOpB, exAluB, exAluResult, exResult;
	isaPkg::regAddr_t exDst;
	logic exZero, exWriteEff;
	// EX/MEM and MEM/WB
	isaPkg::word_t memResult, memStoreData, wbData;
	isaPkg::regAddr_t memDst, wbDst;
	logic memRegWrite, memMemRead, memMemWrite, wbWriteEn;

	// IF
	assign instrAddr = pc;
	assign ifPc4 = pc + 32'd4;
	// Redirect from ID, held while stalled
	assign nextPc = idJumpReg ? idCmpA : idJump ? idJumpTarget : idTaken ? idBranchTarget : ifPc4;
	assign redirect = !stall && (idJump || idJumpReg || idTaken);

	always_ff @(posedge iCLK) begin
		if (iRST) begin
			pc <= initialPc;
			ifIdInstr <= pipePkg::nopInstr;
			ifIdPc4 <= '0;
		end else if (!stall) begin
			pc <= nextPc;
			ifIdInstr <= redirect ? pipePkg::nopInstr : instrData; // No delay slot
			ifIdPc4 <= ifPc4;
		end
	end

	// ID
	controlUnit controlUnit_i (.instr(ifIdInstr), .regDst(idRegDst), .aluSrc(idAluSrc),
		.aluOp(idAluOp), .regWrite(idRegWrite), .memRead(idMemRead), .memWrite(idMemWrite),
		.branchEq(idBranchEq), .branchNe(idBranchNe), .jump(idJump), .jumpReg(idJumpReg),
		.link(idLink), .movN(idMovN), .movZ(idMovZ));

	regFile regFile_i (.iCLK(iCLK), .iRST(iRST), .readAddrA(ifIdInstr.r.rs),
		.readAddrB(ifIdInstr.r.rt), .writeAddr(wbDst), .writeData(wbData),
		.writeEn(wbWriteEn), .readDataA(idRegA), .readDataB(idRegB));

	hazardUnit hazardUnit_i (.idRs(ifIdInstr.r.rs), .idRt(ifIdInstr.r.rt), .exDst(exDst),
		.memDst(memDst), .exMemRead(exMemRead), .exRegWrite(exWriteEff),
		.memMemRead(memMemRead), .usesBranchOperands(idBranchEq || idBranchNe || idJumpReg),
		.stall(stall));

	assign idCmpA = fwdBranchA ? memResult : idRegA; // Also the jr target
	assign idCmpB = fwdBranchB ? memResult : idRegB;
	assign idTaken = (idBranchEq && idCmpA == idCmpB) || (idBranchNe && idCmpA != idCmpB);
	assign idBranchTarget = ifIdPc4 + {{14{ifIdInstr.i.imm[15]}}, ifIdInstr.i.imm, 2'b00};
	assign idJumpTarget = {ifIdPc4[31:28], ifIdInstr.i.rs, ifIdInstr.i.rt,
		ifIdInstr.i.imm, 2'b00};

	// ID/EX, stall puts a bubble here
	always_ff @(posedge iCLK) begin
		if (iRST || stall) begin
			exInstr <= pipePkg::nopInstr;
			exRegDst <= pipePkg::dstRt;
			exAluSrc <= pipePkg::srcReg;
			exAluOp <= pipePkg::aluOpAdd;
			{exRegWrite, exMemRead, exMemWrite, exLink, exMovN, exMovZ} <= '0;
		end else begin
			exInstr <= ifIdInstr;
			exRegDst <= idRegDst;
			exAluSrc <= idAluSrc;
			exAluOp <= idAluOp;
			{exRegWrite, exMemRead, exMemWrite} <= {idRegWrite, idMemRead, idMemWrite};
			{exLink, exMovN, exMovZ} <= {idLink, idMovN, idMovZ};
		end
	end

	always_ff @(posedge iCLK) begin
		exPc4 <= ifIdPc4;
		exRegA <= idRegA;
		exRegB <= idRegB;
	end

	// EX
	forwardUnit forwardUnit_i (.exRs(exInstr.r.rs), .exRt(exInstr.r.rt),
		.idRs(ifIdInstr.r.rs), .idRt(ifIdInstr.r.rt), .memDst(memDst), .wbDst(wbDst),
		.memRegWrite(memRegWrite), .wbWriteEn(wbWriteEn), .fwdA(fwdA), .fwdB(fwdB),
		.fwdBranchA(fwdBranchA), .fwdBranchB(fwdBranchB));

	assign exOpA = (fwdA == pipePkg::fwdFromMem) ? memResult :
		(fwdA == pipePkg::fwdFromWb) ? wbData : exRegA;
	assign exOpB = (fwdB == pipePkg::fwdFromMem) ? memResult :
		(fwdB == pipePkg::fwdFromWb) ? wbData : exRegB;

	always_comb begin
		case (exAluSrc)
			pipePkg::srcSignImm: exAluB = {{16{exInstr.i.imm[15]}}, exInstr.i.imm};
			pipePkg::srcZeroImm: exAluB = {16'h0000, exInstr.i.imm};
			default: exAluB = exOpB;
		endcase
		case (exRegDst)
			pipePkg::dstRd: exDst = exInstr.r.rd;
			pipePkg::dstRa: exDst = isaPkg::regRa;
			default: exDst = exInstr.r.rt;
		endcase
	end

	aluUnit aluUnit_i (.aluOp(exAluOp), .instr(exInstr), .a(exOpA), .b(exAluB),
		.result(exAluResult), .zero(exZero));

	// Link value or moved rs replace the ALU result
	assign exResult = exLink ? exPc4 : (exMovN || exMovZ) ? exOpA : exAluResult;
	assign exWriteEff = exRegWrite || (exMovN && !exZero) || (exMovZ && exZero);

	// EX/MEM
	always_ff @(posedge iCLK) begin
		if (iRST)
			{memRegWrite, memMemRead, memMemWrite} <= '0;
		else
			{memRegWrite, memMemRead, memMemWrite} <= {exWriteEff, exMemRead, exMemWrite};
	end

	always_ff @(posedge iCLK) begin
		memResult <= exResult;
		memStoreData <= exOpB; // sw data is forwarded rt
		memDst <= exDst;
	end

	// MEM, word access only
	assign dataAddr = memResult;
	assign dataWriteData = memStoreData;
	assign dataRead = memMemRead;
	assign dataWrite = memMemWrite;

	// MEM/WB
	always_ff @(posedge iCLK) begin
		if (iRST)
			wbWriteEn <= 1'b0;
		else
			wbWriteEn <= memRegWrite;
		wbData <= memMemRead ? dataReadData : memResult;
		wbDst <= memDst;
	end

endmodule

/* tb/tbMipsChecks.svh */
//**************************************************
// Compare tasks and error counters for the MIPS
// pipeline testbench, included inside tbMips
//**************************************************
`ifndef TB_MIPS_CHECKS_SVH
`define TB_MIPS_CHECKS_SVH

int valueErrors = 0; // Wrong data or address
int storeErrors = 0; // Missing or extra stores

// Data word compare
task automatic checkWord(string name, isaPkg::word_t expected, isaPkg::word_t actual);
	if (actual !== expected) begin
		valueErrors++;
		$display("error at time %0t: %s expected %08h, actual %08h",
			$time, name, expected, actual);
	end
endtask

// Byte address compare, fetch or data side
task automatic checkAddr(string name, isaPkg::word_t expected, isaPkg::word_t actual);
	if (actual !== expected) begin
		valueErrors++;
		$display("error at time %0t: %s expected address %08h, actual %08h",
			$time, name, expected, actual);
	end
endtask

// Single strobe compare
task automatic checkFlag(string name, logic expected, logic actual);
	if (actual !== expected) begin
		valueErrors++;
		$display("error at time %0t: %s expected %b, actual %b",
			$time, name, expected, actual);
	end
endtask

task automatic noteMissingStore(int prog, int idx);
	storeErrors++;
	$display("Program %0d never made its store number %0d", prog, idx);
endtask

task automatic noteExtraStores(int prog, int count);
	storeErrors++;
	$display("Program %0d made %0d more stores than expected", prog, count);
endtask

`endif

/* tb/tbMips.sv */
//**************************************************
// Testbench for the five-stage MIPS core
// Runs a table of small programs, captures every
// data store and compares it with the expected list
//**************************************************
module tbMips;

	localparam int numProgs = 6;
	localparam int progLen = 16; // Words per program
	localparam int maxStores = 8;
	localparam int resetCycles = 16;
	localparam int runCycles = 40; // Enough for every program to reach its self-jump
	localparam isaPkg::word_t progBase = 32'h0000_0040; // Reset PC

	logic iCLK = 1'b0;
	logic iRST;
	isaPkg::word_t initialPc, instrAddr, instrData;
	isaPkg::word_t dataAddr, dataWriteData, dataReadData, fetchOffset;
	logic dataRead, dataWrite;

	isaPkg::word_t progMem [progLen];
	isaPkg::word_t dataMem [64] = '{default: '0};
	isaPkg::word_t progTable [numProgs][progLen];
	isaPkg::word_t expAddr [numProgs][maxStores];
	isaPkg::word_t expData [numProgs][maxStores];
	int progSize [numProgs];
	int expCount [numProgs];
	isaPkg::word_t storeAddrQ [$]; // Every store seen across all programs
	isaPkg::word_t storeDataQ [$];
	int seed;

	`include "tbMipsChecks.svh"

	mipsPipeline dut_i (.iCLK(iCLK), .iRST(iRST), .initialPc(initialPc),
		.instrAddr(instrAddr), .instrData(instrData), .dataAddr(dataAddr),
		.dataWriteData(dataWriteData), .dataRead(dataRead), .dataWrite(dataWrite),
		.dataReadData(dataReadData));

	always #2 iCLK = ~iCLK;

	// Instruction ROM returns nop outside the program
	assign fetchOffset = instrAddr - progBase;
	assign instrData = (fetchOffset < 32'd64) ? progMem[fetchOffset[5:2]] : pipePkg::nopInstr;
	// Word loads from 64 words only while dataRead is high
	assign dataReadData = dataRead ? dataMem[dataAddr[7:2]] : '0;

	// Preset pattern with the inverted low half on top
	function automatic isaPkg::word_t fillValue(isaPkg::word_t addr);
		return {~addr[15:0], addr[15:0]};
	endfunction

	// Stores land at mid-cycle while DUT outputs are steady
	always @(negedge iCLK) begin
		if (iRST) begin
			for (int i = 0; i < 64; i++)
				dataMem[i] = fillValue(isaPkg::word_t'(i * 4)); // Fresh contents each program
		end else if (dataWrite) begin
			dataMem[dataAddr[7:2]] = dataWriteData;
			storeAddrQ.push_back(dataAddr);
			storeDataQ.push_back(dataWriteData);
		end
	end

	// Hand assembler
	function automatic isaPkg::word_t encR(logic [5:0] funct, int rs, int rt, int rd, int shamt);
		isaPkg::instr_t w;
		w.r.opcode = isaPkg::opR;
		w.r.rs = rs[4:0];
		w.r.rt = rt[4:0];
		w.r.rd = rd[4:0];
		w.r.shamt = shamt[4:0];
		w.r.funct = funct;
		return w;
	endfunction

	function automatic isaPkg::word_t encI(logic [5:0] op, int rs, int rt, int imm);
		isaPkg::instr_t w;
		w.i.opcode = op;
		w.i.rs = rs[4:0];
		w.i.rt = rt[4:0];
		w.i.imm = imm[15:0]; // Negative offsets wrap to 16 bits
		return w;
	endfunction

	function automatic isaPkg::word_t encJ(logic [5:0] op, isaPkg::word_t target);
		return {op, target[27:2]};
	endfunction

	function automatic isaPkg::word_t addrOf(int k);
		return progBase + isaPkg::word_t'(4 * k);
	endfunction

	task automatic appendInstr(int p, isaPkg::word_t w);
		progTable[p][progSize[p]] = w;
		progSize[p]++;
	endtask

	task automatic appendSelfJump(int p);
		appendInstr(p, encJ(isaPkg::opJ, addrOf(progSize[p]))); // Parks the core
	endtask

	task automatic appendStore(int p, isaPkg::word_t addr, isaPkg::word_t data);
		expAddr[p][expCount[p]] = addr;
		expData[p][expCount[p]] = data;
		expCount[p]++;
	endtask

	task automatic buildTable();
		isaPkg::word_t t3, v4, v7, v8, v11, a, b;
		for (int p = 0; p < numProgs; p++) begin
			progSize[p] = 0;
			expCount[p] = 0;
			for (int k = 0; k < progLen; k++)
				progTable[p][k] = pipePkg::nopInstr;
		end
		// Dependent ALU chain through MEM and WB forwarding
		appendInstr(0, encI(isaPkg::opAddi, 0, 1, 5));
		appendInstr(0, encI(isaPkg::opAddi, 1, 2, 7));
		appendInstr(0, encR(isaPkg::fnSll, 0, 2, 3, 3));
		appendInstr(0, encR(isaPkg::fnSub, 3, 1, 4, 0));
		appendInstr(0, encI(isaPkg::opOri, 4, 5, 'h0f00));
		appendInstr(0, encR(isaPkg::fnXor, 5, 4, 6, 0)); // rt two back, from WB
		appendInstr(0, encR(isaPkg::fnNor, 6, 1, 7, 0));
		appendInstr(0, encR(isaPkg::fnSlt, 7, 1, 8, 0));
		appendInstr(0, encI(isaPkg::opLui, 0, 9, 'h8123));
		appendInstr(0, encR(isaPkg::fnSrl, 0, 9, 10, 4));
		appendInstr(0, encI(isaPkg::opAndi, 10, 11, 'hf0f0));
		appendInstr(0, encI(isaPkg::opSw, 0, 11, 12)); // Store data from MEM
		appendInstr(0, encI(isaPkg::opSw, 0, 4, 0));
		appendInstr(0, encI(isaPkg::opSw, 0, 7, 4));
		appendInstr(0, encI(isaPkg::opSw, 0, 8, 8));
		appendSelfJump(0);
		t3 = (32'd5 + 32'd7) << 3;
		v4 = t3 - 32'd5;
		v7 = ~(((v4 | 32'h0000_0f00) ^ v4) | 32'd5);
		v8 = ($signed(v7) < $signed(32'd5)) ? 32'd1 : 32'd0;
		v11 = (32'h8123_0000 >> 4) & 32'h0000_f0f0;
		appendStore(0, 32'd12, v11);
		appendStore(0, 32'd0, v4);
		appendStore(0, 32'd4, v7);
		appendStore(0, 32'd8, v8);
		// Load-use bubbles
		appendInstr(1, encI(isaPkg::opAddi, 0, 1, 'h33));
		appendInstr(1, encI(isaPkg::opLw, 0, 2, 16));
		appendInstr(1, encR(isaPkg::fnAdd, 2, 1, 3, 0));
		appendInstr(1, encI(isaPkg::opSw, 0, 3, 32));
		appendInstr(1, encI(isaPkg::opLw, 0, 4, 20));
		appendInstr(1, encI(isaPkg::opSw, 0, 4, 36)); // Loaded value straight to store
		appendInstr(1, encI(isaPkg::opLw, 0, 5, 24));
		appendInstr(1, encI(isaPkg::opAddi, 5, 6, -2));
		appendInstr(1, encI(isaPkg::opSw, 0, 6, 40));
		appendInstr(1, encI(isaPkg::opSw, 0, 1, 44));
		appendInstr(1, encI(isaPkg::opLw, 0, 7, 44)); // Reads back the previous store
		appendInstr(1, encI(isaPkg::opSw, 0, 7, 48));
		appendSelfJump(1);
		appendStore(1, 32'd32, fillValue(32'd16) + 32'h33);
		appendStore(1, 32'd36, fillValue(32'd20));
		appendStore(1, 32'd40, fillValue(32'd24) - 32'd2);
		appendStore(1, 32'd44, 32'h33);
		appendStore(1, 32'd48, 32'h33);
		// Branches on operands produced right before
		appendInstr(2, encI(isaPkg::opAddi, 0, 1, 9));
		appendInstr(2, encI(isaPkg::opAddi, 0, 2, 9));
		appendInstr(2, encI(isaPkg::opBeq, 1, 2, 2)); // Taken to index 5
		appendInstr(2, encI(isaPkg::opSw, 0, 1, 'h80)); // Flushed
		appendInstr(2, encI(isaPkg::opSw, 0, 2, 'h84));
		appendInstr(2, encI(isaPkg::opSw, 0, 1, 'h88));
		appendInstr(2, encI(isaPkg::opAddi, 0, 3, 9));
		appendInstr(2, encI(isaPkg::opBne, 3, 1, 2)); // Not taken
		appendInstr(2, encI(isaPkg::opSw, 0, 3, 'h8c));
		appendInstr(2, encI(isaPkg::opLw, 0, 4, 16));
		appendInstr(2, encI(isaPkg::opBne, 4, 0, 2)); // Two-cycle wait on the load
		appendInstr(2, encI(isaPkg::opSw, 0, 4, 'h90));
		appendInstr(2, encI(isaPkg::opSw, 0, 4, 'h94));
		appendInstr(2, encI(isaPkg::opSw, 0, 4, 'h98));
		appendSelfJump(2);
		appendStore(2, 32'h88, 32'd9);
		appendStore(2, 32'h8c, 32'd9);
		appendStore(2, 32'h98, fillValue(32'd16));
		// jal into a subroutine that returns by jr
		appendInstr(3, encI(isaPkg::opAddi, 0, 1, 'h11));
		appendInstr(3, encJ(isaPkg::opJal, addrOf(6)));
		appendInstr(3, encI(isaPkg::opSw, 0, 1, 'ha0)); // Return point
		appendInstr(3, encI(isaPkg::opSw, 0, 2, 'ha4));
		appendSelfJump(3);
		appendInstr(3, encI(isaPkg::opSw, 0, 1, 'hac)); // Never reached
		appendInstr(3, encI(isaPkg::opSw, 0, 31, 'hb0));
		appendInstr(3, encI(isaPkg::opAddi, 1, 2, 1));
		appendInstr(3, encR(isaPkg::fnJr, 31, 0, 0, 0));
		appendInstr(3, encI(isaPkg::opSw, 0, 2, 'hb4)); // Flushed by jr
		appendStore(3, 32'hb0, addrOf(1) + 32'd4);
		appendStore(3, 32'ha0, 32'h11);
		appendStore(3, 32'ha4, 32'h12);
		// movn and movz under both conditions
		appendInstr(4, encI(isaPkg::opAddi, 0, 1, 'h55));
		appendInstr(4, encI(isaPkg::opAddi, 0, 2, 0));
		appendInstr(4, encI(isaPkg::opAddi, 0, 3, 7));
		appendInstr(4, encI(isaPkg::opAddi, 0, 4, 'h100));
		appendInstr(4, encI(isaPkg::opAddi, 0, 5, 'h200));
		appendInstr(4, encR(isaPkg::fnMovn, 1, 2, 4, 0)); // Zero rt leaves rd alone
		appendInstr(4, encI(isaPkg::opSw, 0, 4, 'hc0));
		appendInstr(4, encR(isaPkg::fnMovn, 1, 3, 5, 0));
		appendInstr(4, encI(isaPkg::opSw, 0, 5, 'hc4));
		appendInstr(4, encR(isaPkg::fnMovz, 3, 2, 4, 0));
		appendInstr(4, encI(isaPkg::opSw, 0, 4, 'hc8));
		appendInstr(4, encR(isaPkg::fnMovz, 3, 3, 5, 0)); // Nonzero rt leaves rd alone
		appendInstr(4, encI(isaPkg::opSw, 0, 5, 'hcc));
		appendSelfJump(4);
		appendStore(4, 32'hc0, 32'h100);
		appendStore(4, 32'hc4, 32'h55);
		appendStore(4, 32'hc8, 32'd7);
		appendStore(4, 32'hcc, 32'h55);
		// Random operands built with lui/ori
		seed = 35;
		a = $random(seed);
		b = $random(seed);
		appendInstr(5, encI(isaPkg::opLui, 0, 1, int'(a[31:16])));
		appendInstr(5, encI(isaPkg::opOri, 1, 1, int'(a[15:0])));
		appendInstr(5, encI(isaPkg::opLui, 0, 2, int'(b[31:16])));
		appendInstr(5, encI(isaPkg::opOri, 2, 2, int'(b[15:0])));
		appendInstr(5, encR(isaPkg::fnAdd, 1, 2, 3, 0));
		appendInstr(5, encI(isaPkg::opSw, 0, 3, 'he0));
		appendInstr(5, encR(isaPkg::fnSub, 1, 2, 4, 0));
		appendInstr(5, encI(isaPkg::opSw, 0, 4, 'he4));
		appendInstr(5, encR(isaPkg::fnSlt, 1, 2, 5, 0));
		appendInstr(5, encI(isaPkg::opSw, 0, 5, 'he8));
		appendSelfJump(5);
		appendStore(5, 32'he0, a + b);
		appendStore(5, 32'he4, a - b);
		appendStore(5, 32'he8, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
	endtask

	// Captured stores against the expected list in order
	task automatic compareStores(int p, int first);
		int got;
		got = storeAddrQ.size() - first;
		for (int s = 0; s < expCount[p]; s++) begin
			if (s >= got) begin
				noteMissingStore(p, s);
			end else begin
				checkAddr("dataAddr", expAddr[p][s], storeAddrQ[first + s]);
				checkWord("dataWriteData", expData[p][s], storeDataQ[first + s]);
			end
		end
		if (got > expCount[p])
			noteExtraStores(p, got - expCount[p]);
	endtask

	task automatic applyProgram(int p);
		int first;
		@(posedge iCLK);
		#1;
		iRST = 1'b1;
		for (int k = 0; k < progLen; k++)
			progMem[k] = progTable[p][k];
		repeat (resetCycles) @(posedge iCLK);
		#1;
		iRST = 1'b0;
		first = storeAddrQ.size();
		@(negedge iCLK); // First cycle out of reset
		checkAddr("instrAddr", progBase, instrAddr);
		checkFlag("dataRead", 1'b0, dataRead);
		checkFlag("dataWrite", 1'b0, dataWrite);
		repeat (runCycles) @(posedge iCLK);
		compareStores(p, first);
	endtask

	initial begin
		iRST = 1'b1;
		initialPc = progBase;
		for (int k = 0; k < progLen; k++)
			progMem[k] = pipePkg::nopInstr;
		buildTable();
		for (int p = 0; p < numProgs; p++)
			applyProgram(p);
		$display("errors: %0d value, %0d store", valueErrors, storeErrors);
		if (valueErrors + storeErrors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

	// Twice the expected run length
	initial begin
		#(numProgs * (resetCycles + runCycles) * 4 * 2);
		$display("Watchdog expired before all programs finished");
		$display("TB FAILED");
		$finish;
	end

endmodule

/* mipsPipeline.f */
+incdir+tb
design/isaPkg.sv
design/pipePkg.sv
design/regFile.sv
design/controlUnit.sv
design/aluUnit.sv
design/forwardUnit.sv
design/hazardUnit.sv
design/mipsPipeline.sv
tb/tbMips.sv

/* run.sh */
#!/usr/bin/env bash
# Build the MIPS pipeline testbench with Verilator, run it, judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tbMips -f mipsPipeline.f -o simMips
./obj_dir/simMips | tee sim.log

if grep -q "TB FAILED" sim.log || ! grep -q "TB PASSED" sim.log; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation passed"
